//--- daq2_pkg.sv
`default_nettype none

package daq2_pkg;

  // register bus word address and data
  typedef logic [3:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // board gpio bank
  typedef logic [16:0] bd_gpio_t;

  // converter control bank, msb first:
  // adc_pd, dac_txen, dac_reset, clkd_sync, adc_fdb, adc_fda, dac_irq, clkd_status[1:0]
  typedef logic [8:0]  cnv_gpio_t;

  // **********************************************************
  // register map
  // **********************************************************
  localparam reg_addr_t ADDR_SPI_CMD    = 4'd0;
  localparam reg_addr_t ADDR_SPI_RDATA  = 4'd1;
  localparam reg_addr_t ADDR_SPI_STATUS = 4'd2;
  localparam reg_addr_t ADDR_BD_OUT     = 4'd4;
  localparam reg_addr_t ADDR_BD_TRI     = 4'd5;
  localparam reg_addr_t ADDR_BD_IN      = 4'd6;
  localparam reg_addr_t ADDR_CNV_OUT    = 4'd8;
  localparam reg_addr_t ADDR_CNV_TRI    = 4'd9;
  localparam reg_addr_t ADDR_CNV_IN     = 4'd10;

  // spi command word fields
  localparam int CMD_CHIP_MSB = 25;
  localparam int CMD_CHIP_LSB = 24;
  localparam int CMD_RD_BIT   = 23;
  localparam int CMD_ADDR_MSB = 22;
  localparam int CMD_ADDR_LSB = 8;
  localparam int CMD_DATA_MSB = 7;
  localparam int CMD_DATA_LSB = 0;

  // chip index, also the chip select bit position
  localparam int CHIP_CLK  = 0;
  localparam int CHIP_DAC  = 1;
  localparam int CHIP_ADC  = 2;
  localparam int CHIP_NONE = 3;

  // frame layout
  localparam int SPI_INSTR_BITS = 16;
  localparam int SPI_FRAME_BITS = 24;

  // sys_clk cycles per spi clock half period
  localparam int SPI_CLK_DIV_DEFAULT = 4;

endpackage

`default_nettype wire

//--- daq2_spi_master.sv
`default_nettype none

module daq2_spi_master #(
  parameter int CLK_DIV = daq2_pkg::SPI_CLK_DIV_DEFAULT
) (
  input  wire logic                sys_clk_i,
  input  wire logic                rst_n_i,
  input  wire logic                start_i,
  input  wire daq2_pkg::reg_data_t cmd_i,
  input  wire logic                spi_miso_i,
  output logic                     busy_o,
  output logic                     done_o,
  output logic [7:0]               rdata_o,
  output logic [2:0]               spi_csn_o,
  output logic                     spi_clk_o,
  output logic                     spi_mosi_o
);

  localparam int DIV_W  = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
  localparam int HALVES = 2 * daq2_pkg::SPI_FRAME_BITS;
  localparam int HALF_W = $clog2(HALVES);
  localparam int FB     = daq2_pkg::SPI_FRAME_BITS;

  logic [DIV_W-1:0]  div_cnt;
  logic [HALF_W-1:0] half_cnt;
  logic [FB-1:0]     tx_sr;
  logic [7:0]        rx_sr;
  logic [1:0]        chip;
  logic [2:0]        csn_sel;
  logic              half_end;

  assign chip       = cmd_i[daq2_pkg::CMD_CHIP_MSB:daq2_pkg::CMD_CHIP_LSB];
  assign csn_sel    = ~(3'b001 << chip);
  assign half_end   = busy_o && (div_cnt == DIV_W'(CLK_DIV - 1));
  assign spi_mosi_o = tx_sr[FB-1];

  // **********************************************************
  // frame sequencer
  // **********************************************************
  // even half periods end with a rising edge, odd ones with a falling edge;
  // the last odd half ends the frame instead
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      busy_o    <= 1'b0;
      done_o    <= 1'b0;
      spi_csn_o <= 3'b111;
      spi_clk_o <= 1'b0;
      div_cnt   <= '0;
      half_cnt  <= '0;
      tx_sr     <= '0;
      rdata_o   <= '0;
    end else begin
      done_o <= 1'b0;
      if (start_i && !busy_o) begin
        busy_o    <= 1'b1;
        spi_csn_o <= csn_sel;
        div_cnt   <= '0;
        half_cnt  <= '0;
        tx_sr     <= cmd_i[FB-1:0];
      end else if (half_end) begin
        div_cnt  <= '0;
        half_cnt <= half_cnt + 1'b1;
        if (!half_cnt[0]) begin
          spi_clk_o <= 1'b1;
        end else begin
          spi_clk_o <= 1'b0;
          if (half_cnt == HALF_W'(HALVES - 1)) begin
            busy_o    <= 1'b0;
            done_o    <= 1'b1;
            spi_csn_o <= 3'b111;
            rdata_o   <= rx_sr;
          end else begin
            // next bit goes out on the falling edge
            tx_sr <= {tx_sr[FB-2:0], 1'b0};
          end
        end
      end else if (busy_o) begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // sample on the rising edge, last 8 bits are the read byte
  always_ff @(posedge sys_clk_i) begin
    if (half_end && !half_cnt[0]) begin
      rx_sr <= {rx_sr[6:0], spi_miso_i};
    end
  end

  // a selected device only while a frame is in progress, never two at once
  a_csn_single: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    !(&spi_csn_o) |-> $onehot(~spi_csn_o) && busy_o);

endmodule

`default_nettype wire

//--- daq2_spi.sv
`default_nettype none

module daq2_spi (
  input  wire logic       sys_clk_i,
  input  wire logic       rst_n_i,
  input  wire logic [2:0] spi_csn_i,
  input  wire logic       spi_clk_i,
  input  wire logic       spi_mosi_i,
  input  wire logic       spi_sdio_i,
  output logic            spi_miso_o,
  output logic            spi_sdio_o,
  output logic            spi_sdio_t_o,
  output logic            spi_dir_o
);

  localparam int CNT_W = $clog2(daq2_pkg::SPI_FRAME_BITS + 1);

  logic             clk_d;
  logic             clk_rise;
  logic             frame_idle;
  logic [CNT_W-1:0] bit_cnt;
  logic             rd_flag;
  logic             rd_turn;

  assign frame_idle = &spi_csn_i;
  assign clk_rise   = spi_clk_i && !clk_d;

  // **********************************************************
  // instruction tracking
  // **********************************************************
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      clk_d   <= 1'b0;
      bit_cnt <= '0;
      rd_flag <= 1'b0;
      rd_turn <= 1'b0;
    end else begin
      clk_d <= spi_clk_i;
      if (frame_idle) begin
        bit_cnt <= '0;
        rd_flag <= 1'b0;
        rd_turn <= 1'b0;
      end else if (clk_rise) begin
        bit_cnt <= bit_cnt + 1'b1;
        // first bit of the instruction is r/w
        if (bit_cnt == '0) begin
          rd_flag <= spi_mosi_i;
        end
        // instruction done, device owns the line for the data phase
        if (rd_flag && (bit_cnt == CNT_W'(daq2_pkg::SPI_INSTR_BITS - 1))) begin
          rd_turn <= 1'b1;
        end
      end
    end
  end

  // release ends with the chip select, not a cycle later
  assign spi_sdio_t_o = rd_turn && !frame_idle;
  assign spi_dir_o    = !spi_sdio_t_o;
  assign spi_sdio_o   = spi_mosi_i;
  assign spi_miso_o   = spi_sdio_i;

  // read direction only inside a frame that was already open a cycle before
  a_dir_in_frame: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    !spi_dir_o |-> !frame_idle && !$past(frame_idle));

endmodule

`default_nettype wire

//--- daq2_gpio.sv
`default_nettype none

module daq2_gpio #(
  parameter type gpio_t = logic [7:0]
) (
  input  wire logic  sys_clk_i,
  input  wire logic  rst_n_i,
  input  wire logic  out_we_i,
  input  wire logic  tri_we_i,
  input  wire gpio_t wdata_i,
  input  wire gpio_t pad_i,
  output gpio_t      pad_o,
  output gpio_t      pad_t_o,
  output gpio_t      in_o,
  output gpio_t      out_o,
  output gpio_t      tri_o
);

  gpio_t out_q;
  gpio_t tri_q;
  gpio_t in_meta;
  gpio_t in_sync;

  // **********************************************************
  // output and tristate registers
  // **********************************************************
  // all pads come up released
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      tri_q <= '1;
    end else begin
      if (out_we_i) begin
        out_q <= wdata_i;
      end
      if (tri_we_i) begin
        tri_q <= wdata_i;
      end
    end
  end

  // two flop synchronizer on the pad inputs
  always_ff @(posedge sys_clk_i) begin
    in_meta <= pad_i;
    in_sync <= in_meta;
  end

  // pad side, 1 in tristate means released
  assign pad_o   = out_q;
  assign pad_t_o = tri_q;

  // register side
  assign out_o = out_q;
  assign tri_o = tri_q;
  assign in_o  = in_sync;

endmodule

`default_nettype wire

//--- daq2_regmap.sv
`default_nettype none

module daq2_regmap (
  input  wire logic                 sys_clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 wr_i,
  input  wire logic                 rd_i,
  input  wire daq2_pkg::reg_addr_t  addr_i,
  input  wire daq2_pkg::reg_data_t  wdata_i,
  input  wire logic                 spi_busy_i,
  input  wire logic [7:0]           spi_rdata_i,
  input  wire daq2_pkg::bd_gpio_t   bd_in_i,
  input  wire daq2_pkg::bd_gpio_t   bd_out_i,
  input  wire daq2_pkg::bd_gpio_t   bd_tri_i,
  input  wire daq2_pkg::cnv_gpio_t  cnv_in_i,
  input  wire daq2_pkg::cnv_gpio_t  cnv_out_i,
  input  wire daq2_pkg::cnv_gpio_t  cnv_tri_i,
  output daq2_pkg::reg_data_t       rdata_o,
  output logic                      rvalid_o,
  output logic                      spi_start_o,
  output daq2_pkg::reg_data_t       spi_cmd_o,
  output logic                      bd_out_we_o,
  output logic                      bd_tri_we_o,
  output logic                      cnv_out_we_o,
  output logic                      cnv_tri_we_o
);

  logic                cmd_wr;
  logic                cmd_ok;
  logic                spi_pending;
  daq2_pkg::reg_data_t rd_mux;

  // **********************************************************
  // write decode
  // **********************************************************
  assign cmd_wr = wr_i && (addr_i == daq2_pkg::ADDR_SPI_CMD);

  // start already in flight counts as busy
  assign spi_pending = spi_busy_i || spi_start_o;
  assign cmd_ok = !spi_pending &&
                  (wdata_i[daq2_pkg::CMD_CHIP_MSB:daq2_pkg::CMD_CHIP_LSB] !=
                   2'(daq2_pkg::CHIP_NONE));

  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      spi_start_o <= 1'b0;
    end else begin
      spi_start_o <= cmd_wr && cmd_ok;
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (cmd_wr && cmd_ok) begin
      spi_cmd_o <= wdata_i;
    end
  end

  // gpio banks register the data themselves
  assign bd_out_we_o  = wr_i && (addr_i == daq2_pkg::ADDR_BD_OUT);
  assign bd_tri_we_o  = wr_i && (addr_i == daq2_pkg::ADDR_BD_TRI);
  assign cnv_out_we_o = wr_i && (addr_i == daq2_pkg::ADDR_CNV_OUT);
  assign cnv_tri_we_o = wr_i && (addr_i == daq2_pkg::ADDR_CNV_TRI);

  // **********************************************************
  // readback
  // **********************************************************
  always_comb begin
    rd_mux = '0;
    case (addr_i)
      daq2_pkg::ADDR_SPI_RDATA:  rd_mux = daq2_pkg::reg_data_t'(spi_rdata_i);
      daq2_pkg::ADDR_SPI_STATUS: rd_mux[0] = spi_pending;
      daq2_pkg::ADDR_BD_OUT:     rd_mux = daq2_pkg::reg_data_t'(bd_out_i);
      daq2_pkg::ADDR_BD_TRI:     rd_mux = daq2_pkg::reg_data_t'(bd_tri_i);
      daq2_pkg::ADDR_BD_IN:      rd_mux = daq2_pkg::reg_data_t'(bd_in_i);
      daq2_pkg::ADDR_CNV_OUT:    rd_mux = daq2_pkg::reg_data_t'(cnv_out_i);
      daq2_pkg::ADDR_CNV_TRI:    rd_mux = daq2_pkg::reg_data_t'(cnv_tri_i);
      daq2_pkg::ADDR_CNV_IN:     rd_mux = daq2_pkg::reg_data_t'(cnv_in_i);
      default:                   rd_mux = '0;
    endcase
  end

  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      rvalid_o <= rd_i;
      if (rd_i) begin
        rdata_o <= rd_mux;
      end
    end
  end

  // back to back rvalid only for back to back reads
  a_rvalid_pair: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    rvalid_o && $past(rvalid_o) |-> $past(rd_i) && $past(rd_i, 2));

endmodule

`default_nettype wire

//--- daq2_top.sv
`default_nettype none

module daq2_top #(
  parameter int CLK_DIV = daq2_pkg::SPI_CLK_DIV_DEFAULT
) (
  input  wire logic                 sys_clk_i,
  input  wire logic                 rst_n_i,
  input  wire logic                 wr_i,
  input  wire logic                 rd_i,
  input  wire daq2_pkg::reg_addr_t  addr_i,
  input  wire daq2_pkg::reg_data_t  wdata_i,
  input  wire logic                 spi_sdio_i,
  input  wire daq2_pkg::bd_gpio_t   gpio_bd_i,
  input  wire daq2_pkg::cnv_gpio_t  gpio_cnv_i,
  output daq2_pkg::reg_data_t       rdata_o,
  output logic                      rvalid_o,
  output logic                      spi_done_o,
  output logic                      spi_csn_clk_o,
  output logic                      spi_csn_dac_o,
  output logic                      spi_csn_adc_o,
  output logic                      spi_clk_o,
  output logic                      spi_sdio_o,
  output logic                      spi_sdio_t_o,
  output logic                      spi_dir_o,
  output daq2_pkg::bd_gpio_t        gpio_bd_o,
  output daq2_pkg::bd_gpio_t        gpio_bd_t_o,
  output daq2_pkg::cnv_gpio_t       gpio_cnv_o,
  output daq2_pkg::cnv_gpio_t       gpio_cnv_t_o
);

  localparam int BD_W  = $bits(daq2_pkg::bd_gpio_t);
  localparam int CNV_W = $bits(daq2_pkg::cnv_gpio_t);

  // spi path
  logic                spi_start;
  daq2_pkg::reg_data_t spi_cmd;
  logic                spi_busy;
  logic [7:0]          spi_rdata;
  logic [2:0]          spi_csn;
  logic                spi_mosi;
  logic                spi_miso;

  // gpio register side
  logic                bd_out_we;
  logic                bd_tri_we;
  logic                cnv_out_we;
  logic                cnv_tri_we;
  daq2_pkg::bd_gpio_t  bd_in;
  daq2_pkg::bd_gpio_t  bd_out;
  daq2_pkg::bd_gpio_t  bd_tri;
  daq2_pkg::cnv_gpio_t cnv_in;
  daq2_pkg::cnv_gpio_t cnv_out;
  daq2_pkg::cnv_gpio_t cnv_tri;

  // chip selects by device
  assign spi_csn_clk_o = spi_csn[daq2_pkg::CHIP_CLK];
  assign spi_csn_dac_o = spi_csn[daq2_pkg::CHIP_DAC];
  assign spi_csn_adc_o = spi_csn[daq2_pkg::CHIP_ADC];

  // **********************************************************
  // instances
  // **********************************************************
  daq2_regmap i_regmap (
    .sys_clk_i    (sys_clk_i),
    .rst_n_i      (rst_n_i),
    .wr_i         (wr_i),
    .rd_i         (rd_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .spi_busy_i   (spi_busy),
    .spi_rdata_i  (spi_rdata),
    .bd_in_i      (bd_in),
    .bd_out_i     (bd_out),
    .bd_tri_i     (bd_tri),
    .cnv_in_i     (cnv_in),
    .cnv_out_i    (cnv_out),
    .cnv_tri_i    (cnv_tri),
    .rdata_o      (rdata_o),
    .rvalid_o     (rvalid_o),
    .spi_start_o  (spi_start),
    .spi_cmd_o    (spi_cmd),
    .bd_out_we_o  (bd_out_we),
    .bd_tri_we_o  (bd_tri_we),
    .cnv_out_we_o (cnv_out_we),
    .cnv_tri_we_o (cnv_tri_we)
  );

  daq2_spi_master #(
    .CLK_DIV (CLK_DIV)
  ) i_spi_master (
    .sys_clk_i  (sys_clk_i),
    .rst_n_i    (rst_n_i),
    .start_i    (spi_start),
    .cmd_i      (spi_cmd),
    .spi_miso_i (spi_miso),
    .busy_o     (spi_busy),
    .done_o     (spi_done_o),
    .rdata_o    (spi_rdata),
    .spi_csn_o  (spi_csn),
    .spi_clk_o  (spi_clk_o),
    .spi_mosi_o (spi_mosi)
  );

  daq2_spi i_spi (
    .sys_clk_i    (sys_clk_i),
    .rst_n_i      (rst_n_i),
    .spi_csn_i    (spi_csn),
    .spi_clk_i    (spi_clk_o),
    .spi_mosi_i   (spi_mosi),
    .spi_sdio_i   (spi_sdio_i),
    .spi_miso_o   (spi_miso),
    .spi_sdio_o   (spi_sdio_o),
    .spi_sdio_t_o (spi_sdio_t_o),
    .spi_dir_o    (spi_dir_o)
  );

  daq2_gpio #(
    .gpio_t (daq2_pkg::bd_gpio_t)
  ) i_gpio_bd (
    .sys_clk_i (sys_clk_i),
    .rst_n_i   (rst_n_i),
    .out_we_i  (bd_out_we),
    .tri_we_i  (bd_tri_we),
    .wdata_i   (wdata_i[BD_W-1:0]),
    .pad_i     (gpio_bd_i),
    .pad_o     (gpio_bd_o),
    .pad_t_o   (gpio_bd_t_o),
    .in_o      (bd_in),
    .out_o     (bd_out),
    .tri_o     (bd_tri)
  );

  daq2_gpio #(
    .gpio_t (daq2_pkg::cnv_gpio_t)
  ) i_gpio_cnv (
    .sys_clk_i (sys_clk_i),
    .rst_n_i   (rst_n_i),
    .out_we_i  (cnv_out_we),
    .tri_we_i  (cnv_tri_we),
    .wdata_i   (wdata_i[CNV_W-1:0]),
    .pad_i     (gpio_cnv_i),
    .pad_o     (gpio_cnv_o),
    .pad_t_o   (gpio_cnv_t_o),
    .in_o      (cnv_in),
    .out_o     (cnv_out),
    .tri_o     (cnv_tri)
  );

endmodule

`default_nettype wire

//--- tb_spi_slave.sv
`default_nettype none

module tb_spi_slave (
  input  wire logic [2:0] spi_csn_i,
  input  wire logic       spi_clk_i,
  input  wire logic       spi_sdio_i,
  input  wire logic       spi_sdio_t_i,
  input  wire logic       spi_dir_i,
  output logic            spi_sdio_o,
  output logic            error_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int FB = daq2_pkg::SPI_FRAME_BITS;
  localparam int IB = daq2_pkg::SPI_INSTR_BITS;

  // one byte memory per device, keyed by {chip, addr}
  logic [7:0] mem [int];

  function automatic logic [7:0] mem_read(input logic [1:0] chip, input logic [14:0] addr);
    if (mem.exists(int'({chip, addr}))) begin
      return mem[int'({chip, addr})];
    end
    return addr[7:0] ^ (8'(chip) * 8'h55);
  endfunction

  function automatic logic [1:0] chip_of(input logic [2:0] csn);
    case (csn)
      3'b110:  return 2'd0;
      3'b101:  return 2'd1;
      default: return 2'd2;
    endcase
  endfunction

  // **********************************************************
  // frame decoder
  // **********************************************************
  initial begin
    logic [FB-1:0] sr;
    logic [1:0]    chip;
    logic          rd_op;
    logic [14:0]   addr;
    logic [7:0]    rbyte;
    spi_sdio_o = 1'b0;
    error_o    = 1'b0;
    forever begin
      wait (spi_csn_i != 3'b111);
      chip  = chip_of(spi_csn_i);
      sr    = '0;
      rd_op = 1'b0;
      addr  = '0;
      rbyte = '0;
      for (int i = 0; i < FB; i++) begin
        @(posedge spi_clk_i);
        sr = {sr[FB-2:0], spi_sdio_i};
        // instruction complete: r/w flag and 15 bit address
        if (i == IB - 1) begin
          rd_op = sr[IB-1];
          addr  = sr[IB-2:0];
          rbyte = mem_read(chip, addr);
        end
        // read data goes out on the falling edges after the instruction
        if (rd_op && i >= IB - 1 && i < FB - 1) begin
          @(negedge spi_clk_i);
          if (spi_sdio_t_i !== 1'b1 || spi_dir_i !== 1'b0) begin
            $display("spi device: host still drives the data line when read data is due");
            error_o = 1'b1;
          end
          #2;
          spi_sdio_o = rbyte[FB-2-i];
        end
      end
      wait (spi_csn_i == 3'b111);
      spi_sdio_o = 1'b0;
      if (!rd_op) begin
        mem[int'({chip, addr})] = sr[7:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_daq2.sv
`default_nettype none

module tb_daq2;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_DIV = 4;
  // a frame is 48 half periods plus bus and polling overhead
  localparam int FRAME_CYCLES   = 2 * daq2_pkg::SPI_FRAME_BITS * CLK_DIV + 28;
  localparam int MAX_FRAMES     = 40;
  localparam int TIMEOUT_CYCLES = 2 * MAX_FRAMES * FRAME_CYCLES + 2400;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 bus_wr;
  logic                 bus_rd;
  daq2_pkg::reg_addr_t  bus_addr;
  daq2_pkg::reg_data_t  bus_wdata;
  daq2_pkg::reg_data_t  rdata;
  logic                 rvalid;
  logic                 spi_done;
  logic                 csn_clk;
  logic                 csn_dac;
  logic                 csn_adc;
  logic                 spi_clk;
  logic                 sdio_out;
  logic                 sdio_t;
  logic                 spi_dir;
  logic                 sdio_in;
  logic                 slave_err;
  daq2_pkg::bd_gpio_t   pad_bd_in;
  daq2_pkg::bd_gpio_t   pad_bd_out;
  daq2_pkg::bd_gpio_t   pad_bd_t;
  daq2_pkg::cnv_gpio_t  pad_cnv_in;
  daq2_pkg::cnv_gpio_t  pad_cnv_out;
  daq2_pkg::cnv_gpio_t  pad_cnv_t;
  wire logic [2:0]      spi_csn;

  string      test_name = "init";
  int         frame_cnt = 0;
  int         cycle_cnt = 0;
  logic [7:0] shadow [int];

  assign spi_csn = {csn_adc, csn_dac, csn_clk};

  always #10 clk = ~clk;

  daq2_top #(
    .CLK_DIV (CLK_DIV)
  ) i_dut (
    .sys_clk_i     (clk),
    .rst_n_i       (rst_n),
    .wr_i          (bus_wr),
    .rd_i          (bus_rd),
    .addr_i        (bus_addr),
    .wdata_i       (bus_wdata),
    .spi_sdio_i    (sdio_in),
    .gpio_bd_i     (pad_bd_in),
    .gpio_cnv_i    (pad_cnv_in),
    .rdata_o       (rdata),
    .rvalid_o      (rvalid),
    .spi_done_o    (spi_done),
    .spi_csn_clk_o (csn_clk),
    .spi_csn_dac_o (csn_dac),
    .spi_csn_adc_o (csn_adc),
    .spi_clk_o     (spi_clk),
    .spi_sdio_o    (sdio_out),
    .spi_sdio_t_o  (sdio_t),
    .spi_dir_o     (spi_dir),
    .gpio_bd_o     (pad_bd_out),
    .gpio_bd_t_o   (pad_bd_t),
    .gpio_cnv_o    (pad_cnv_out),
    .gpio_cnv_t_o  (pad_cnv_t)
  );

  tb_spi_slave i_slave (
    .spi_csn_i    (spi_csn),
    .spi_clk_i    (spi_clk),
    .spi_sdio_i   (sdio_out),
    .spi_sdio_t_i (sdio_t),
    .spi_dir_i    (spi_dir),
    .spi_sdio_o   (sdio_in),
    .error_o      (slave_err)
  );

  // **********************************************************
  // reference model and compare tasks
  // **********************************************************
  // device memory shadow where untouched bytes follow the power up pattern
  function automatic logic [7:0] exp_spi_read(input logic [1:0] chip, input logic [14:0] addr);
    if (shadow.exists(int'({chip, addr}))) begin
      return shadow[int'({chip, addr})];
    end
    return addr[7:0] ^ (8'(chip) * 8'h55);
  endfunction

  function automatic void record_spi_write(input logic [1:0] chip, input logic [14:0] addr,
                                           input logic [7:0] data);
    shadow[int'({chip, addr})] = data;
  endfunction

  function automatic daq2_pkg::reg_data_t make_cmd(input logic [1:0] chip, input logic rd_op,
                                                   input logic [14:0] addr, input logic [7:0] data);
    daq2_pkg::reg_data_t cmd;
    cmd = '0;
    cmd[daq2_pkg::CMD_CHIP_MSB:daq2_pkg::CMD_CHIP_LSB] = chip;
    cmd[daq2_pkg::CMD_RD_BIT] = rd_op;
    cmd[daq2_pkg::CMD_ADDR_MSB:daq2_pkg::CMD_ADDR_LSB] = addr;
    cmd[daq2_pkg::CMD_DATA_MSB:daq2_pkg::CMD_DATA_LSB] = data;
    return cmd;
  endfunction

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(input string what, input daq2_pkg::reg_data_t exp,
                            input daq2_pkg::reg_data_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bd(input string what, input daq2_pkg::bd_gpio_t exp,
                          input daq2_pkg::bd_gpio_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_cnv(input string what, input daq2_pkg::cnv_gpio_t exp,
                           input daq2_pkg::cnv_gpio_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %b actual %b", test_name, what, exp, act);
      abort_run();
    end
  endtask

  // **********************************************************
  // bus tasks
  // **********************************************************
  task automatic bus_write(input daq2_pkg::reg_addr_t a, input daq2_pkg::reg_data_t d);
    @(posedge clk);
    #2;
    bus_wr    = 1'b1;
    bus_addr  = a;
    bus_wdata = d;
    @(posedge clk);
    #2;
    bus_wr    = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
  endtask

  // read data comes exactly one cycle after the request
  task automatic bus_read(input daq2_pkg::reg_addr_t a, output daq2_pkg::reg_data_t d);
    @(posedge clk);
    #2;
    bus_rd   = 1'b1;
    bus_addr = a;
    @(posedge clk);
    #2;
    bus_rd   = 1'b0;
    bus_addr = '0;
    check_bit("rvalid", 1'b1, rvalid);
    d = rdata;
  endtask

  task automatic wait_idle();
    daq2_pkg::reg_data_t st;
    st = 32'h1;
    while (st[0]) begin
      bus_read(daq2_pkg::ADDR_SPI_STATUS, st);
    end
  endtask

  task automatic spi_xfer(input logic [1:0] chip, input logic rd_op, input logic [14:0] addr,
                          input logic [7:0] data);
    bus_write(daq2_pkg::ADDR_SPI_CMD, make_cmd(chip, rd_op, addr, data));
    wait_idle();
  endtask

  // **********************************************************
  // frame monitor for turnaround, done and frame count
  // **********************************************************
  logic mon_clk_q;
  logic mon_open_q;
  logic mon_rd;
  logic mon_turn;
  int   mon_rises;
  logic rd_q;

  always @(posedge clk) begin : frame_monitor
    logic frame_open;
    if (!rst_n) begin
      mon_clk_q  = 1'b0;
      mon_open_q = 1'b0;
      mon_rd     = 1'b0;
      mon_turn   = 1'b0;
      mon_rises  = 0;
    end else begin
      frame_open = (spi_csn != 3'b111);
      if (frame_open && !mon_open_q) begin
        frame_cnt++;
      end
      if (!frame_open) begin
        mon_rises = 0;
        mon_rd    = 1'b0;
        mon_turn  = 1'b0;
      end
      check_bit("spi_dir", !(frame_open && mon_turn), spi_dir);
      check_bit("spi_sdio_t", frame_open && mon_turn, sdio_t);
      // done pulses once, together with the chip select release
      check_bit("spi_done", !frame_open && mon_open_q, spi_done);
      if (frame_open && spi_clk && !mon_clk_q) begin
        mon_rises++;
        if (mon_rises == 1) begin
          mon_rd = sdio_out;
        end
        // device owns the line once the instruction is in
        if (mon_rd && mon_rises == daq2_pkg::SPI_INSTR_BITS) begin
          mon_turn = 1'b1;
        end
      end
      mon_clk_q  = spi_clk;
      mon_open_q = frame_open;
    end
  end

  // rvalid is high for one cycle after each read request and low otherwise
  always @(posedge clk) begin
    if (!rst_n) begin
      rd_q = 1'b0;
    end else begin
      check_bit("rvalid", rd_q, rvalid);
      rd_q = bus_rd;
    end
  end

  always @(posedge slave_err) begin
    abort_run();
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  // **********************************************************
  // tests
  // **********************************************************
  task automatic test_reset();
    daq2_pkg::reg_data_t r;
    test_name = "reset";
    check_bit("csn_clk", 1'b1, csn_clk);
    check_bit("csn_dac", 1'b1, csn_dac);
    check_bit("csn_adc", 1'b1, csn_adc);
    check_bit("spi_clk", 1'b0, spi_clk);
    check_bit("spi_dir", 1'b1, spi_dir);
    check_bit("spi_done", 1'b0, spi_done);
    check_bd("bd tri", '1, pad_bd_t);
    check_bd("bd out", '0, pad_bd_out);
    check_cnv("cnv tri", '1, pad_cnv_t);
    check_cnv("cnv out", '0, pad_cnv_out);
    bus_read(daq2_pkg::ADDR_SPI_STATUS, r);
    check_data("status", '0, r);
  endtask

  task automatic test_spi_rw();
    logic [1:0]          chip;
    logic [14:0]         a;
    logic [7:0]          d;
    daq2_pkg::reg_data_t r;
    test_name = "spi write/read";
    for (int n = 0; n < 15; n++) begin
      chip = 2'($urandom_range(2, 0));
      a    = 15'($urandom);
      d    = 8'($urandom);
      spi_xfer(chip, 1'b0, a, d);
      record_spi_write(chip, a, d);
      // half of the reads go to a fresh location
      if ($urandom_range(1, 0) == 0) begin
        chip = 2'($urandom_range(2, 0));
        a    = 15'($urandom);
      end
      spi_xfer(chip, 1'b1, a, 8'h00);
      bus_read(daq2_pkg::ADDR_SPI_RDATA, r);
      check_data("rdata", {24'h0, exp_spi_read(chip, a)}, r);
    end
  endtask

  task automatic test_reject();
    logic [1:0]          chip;
    logic [14:0]         a;
    logic [7:0]          d;
    int                  frames;
    daq2_pkg::reg_data_t r;
    test_name = "reject";
    chip   = 2'($urandom_range(2, 0));
    a      = 15'($urandom);
    d      = 8'($urandom);
    frames = frame_cnt;
    bus_write(daq2_pkg::ADDR_SPI_CMD, make_cmd(chip, 1'b0, a, d));
    bus_write(daq2_pkg::ADDR_SPI_CMD, make_cmd(chip, 1'b0, a ^ 15'h1, ~d));
    wait_idle();
    record_spi_write(chip, a, d);
    check_data("frames while busy", daq2_pkg::reg_data_t'(frames + 1),
               daq2_pkg::reg_data_t'(frame_cnt));
    spi_xfer(chip, 1'b1, a ^ 15'h1, 8'h00);
    bus_read(daq2_pkg::ADDR_SPI_RDATA, r);
    check_data("busy write dropped", {24'h0, exp_spi_read(chip, a ^ 15'h1)}, r);
    frames = frame_cnt;
    bus_write(daq2_pkg::ADDR_SPI_CMD, make_cmd(2'd3, 1'b0, a, ~d));
    // no frame may start within a few half periods
    repeat (4 * CLK_DIV) @(posedge clk);
    #2;
    check_data("frames chip 3", daq2_pkg::reg_data_t'(frames),
               daq2_pkg::reg_data_t'(frame_cnt));
    bus_read(daq2_pkg::ADDR_SPI_STATUS, r);
    check_data("status chip 3", '0, r);
  endtask

  task automatic test_gpio_out();
    daq2_pkg::bd_gpio_t  bo;
    daq2_pkg::bd_gpio_t  bt;
    daq2_pkg::cnv_gpio_t co;
    daq2_pkg::cnv_gpio_t ct;
    daq2_pkg::reg_data_t r;
    test_name = "gpio out";
    for (int n = 0; n < 8; n++) begin
      bo = 17'($urandom);
      bt = 17'($urandom);
      co = 9'($urandom);
      ct = 9'($urandom);
      bus_write(daq2_pkg::ADDR_BD_OUT, {15'h0, bo});
      bus_write(daq2_pkg::ADDR_BD_TRI, {15'h0, bt});
      bus_write(daq2_pkg::ADDR_CNV_OUT, {23'h0, co});
      bus_write(daq2_pkg::ADDR_CNV_TRI, {23'h0, ct});
      check_bd("bd pad", bo, pad_bd_out);
      check_bd("bd pad_t", bt, pad_bd_t);
      check_cnv("cnv pad", co, pad_cnv_out);
      check_cnv("cnv pad_t", ct, pad_cnv_t);
      bus_read(daq2_pkg::ADDR_BD_TRI, r);
      check_data("bd tri reg", {15'h0, bt}, r);
      bus_read(daq2_pkg::ADDR_CNV_OUT, r);
      check_data("cnv out reg", {23'h0, co}, r);
    end
  endtask

  task automatic test_gpio_in();
    daq2_pkg::reg_data_t r;
    test_name = "gpio in";
    for (int n = 0; n < 8; n++) begin
      @(posedge clk);
      #2;
      pad_bd_in  = 17'($urandom);
      pad_cnv_in = 9'($urandom);
      repeat (3) @(posedge clk);
      bus_read(daq2_pkg::ADDR_BD_IN, r);
      check_bd("bd in", pad_bd_in, r[16:0]);
      bus_read(daq2_pkg::ADDR_CNV_IN, r);
      check_cnv("cnv in", pad_cnv_in, r[8:0]);
    end
  endtask

  initial begin
    void'($urandom(32'h8fb3));
    rst_n      = 1'b0;
    bus_wr     = 1'b0;
    bus_rd     = 1'b0;
    bus_addr   = '0;
    bus_wdata  = '0;
    pad_bd_in  = '0;
    pad_cnv_in = '0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_reset();
    test_spi_rw();
    test_reject();
    test_gpio_out();
    test_gpio_in();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
daq2_pkg.sv
daq2_spi_master.sv
daq2_spi.sv
daq2_gpio.sv
daq2_regmap.sv
daq2_top.sv
tb_spi_slave.sv
tb_daq2.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the daq2 control path simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_daq2 -f files.f -o tb_daq2

# the simulator exit code is not trusted, the log decides
./obj_dir/tb_daq2 > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi

if ! grep -q "Everything OK" sim.log; then
  echo "simulation did not complete"
  exit 1
fi

echo "simulation passed"
